// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = spmm_tb
FLIST = files.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// ==== files.f ====
hdl/spmm_pkg.sv
hdl/simple_dp_ram.sv
hdl/sync_fifo.sv
hdl/spmm_ctrl.sv
hdl/sp_pe.sv
hdl/wh_writeback.sv
hdl/spmm_top.sv
verification/clk_rst_gen.sv
verification/spmm_sva.sv
verification/spmm_tb.sv

// ==== hdl/simple_dp_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module simple_dp_ram #(
  parameter type T = logic [7:0],
  parameter int DEPTH = 16,
  localparam int AW = $clog2(DEPTH)
) (
  input  wire logic          clk,
  input  wire logic          we_i,
  input  wire logic [AW-1:0] waddr_i,
  input  wire T              wdata_i,
  input  wire logic [AW-1:0] raddr_i,
  output T                   rdata_o
);

  T mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    // read data one cycle after the address
    rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

// ==== hdl/sp_pe.sv ====
`timescale 1ns/1ns
`default_nettype none

module sp_pe import spmm_pkg::*; (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 ld_we_i,
  input  wire logic [COL_IDX_W-1:0] ld_addr_i,
  input  wire data_t                ld_data_i,
  input  wire logic                 ent_valid_i,
  input  wire logic [COL_IDX_W-1:0] ent_col_i,
  input  wire data_t                ent_val_i,
  input  wire logic                 ent_last_i,
  output logic                      res_valid_o,
  output acc_t                      res_o
);

  data_t weight;
  data_t s1_val;
  logic  s1_valid;
  logic  s1_last;
  logic  clear_q;
  acc_t  acc_q;
  acc_t  prod;
  acc_t  sum;

  // this PE's column of W, indexed by column index of H
  simple_dp_ram #(
    .T     (data_t),
    .DEPTH (2 ** COL_IDX_W)
  ) u_weight_ram (
    .clk     (clk),
    .we_i    (ld_we_i),
    .waddr_i (ld_addr_i),
    .wdata_i (ld_data_i),
    .raddr_i (ent_col_i),
    .rdata_o (weight)
  );

  // stage one, wait for the weight
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
    end else begin
      s1_valid <= ent_valid_i;
      s1_last  <= ent_valid_i && ent_last_i;
    end
  end

  always_ff @(posedge clk) begin
    s1_val <= ent_val_i;
  end

  // signed operands are extended to the accumulator width first
  assign prod = s1_val * weight;
  assign sum  = (clear_q ? acc_t'(0) : acc_q) + prod;

  // stage two, accumulate
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clear_q     <= 1'b1;
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= s1_valid && s1_last;
      if (s1_valid) begin
        clear_q <= s1_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      acc_q <= sum;
    end
    if (s1_valid && s1_last) begin
      res_o <= sum;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/spmm_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module spmm_ctrl import spmm_pkg::*; (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    start_i,
  input  wire logic [NUM_ROWS_W-1:0]   num_rows_i,
  input  wire logic                    done_i,
  output logic                         busy_o,
  output logic [ROW_W-1:0]             node_addr_o,
  input  wire node_info_t              node_i,
  output logic [ENTRY_ADDR_W-1:0]      ent_addr_o,
  input  wire entry_t                  ent_i,
  output logic                         ent_valid_o,
  output logic [COL_IDX_W-1:0]         ent_col_o,
  output data_t                        ent_val_o,
  output logic                         ent_last_o,
  output logic                         meta_push_o,
  output row_meta_t                    meta_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_STREAM
  } state_t;

  state_t                  state_q;
  logic                    busy_q;
  logic                    first_q;
  logic [ROW_W-1:0]        row_q;
  logic [NUM_ROWS_W-1:0]   num_rows_q;
  logic [ROW_LEN_W-1:0]    rem_q;
  logic [ROW_LEN_W-1:0]    len;
  logic [ENTRY_ADDR_W-1:0] ent_addr_q;
  logic                    req_q;
  logic                    req_last_q;
  logic                    req_first_q;
  logic                    last_req;
  logic                    last_row;
  row_meta_t               meta_q;

  // node word is valid on the first stream cycle only after the fetch
  assign len      = first_q ? node_i.row_len : rem_q;
  assign last_req = (state_q == S_STREAM) && (len == ROW_LEN_W'(1));
  assign last_row = ({1'b0, row_q} + 1'b1) == num_rows_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q     <= S_IDLE;
      busy_q      <= 1'b0;
      first_q     <= 1'b0;
      row_q       <= '0;
      num_rows_q  <= '0;
      rem_q       <= '0;
      ent_addr_q  <= '0;
      req_q       <= 1'b0;
      req_last_q  <= 1'b0;
      req_first_q <= 1'b0;
    end else begin
      req_q       <= (state_q == S_STREAM);
      req_last_q  <= last_req;
      req_first_q <= (state_q == S_STREAM) && first_q;
      if (done_i) begin
        busy_q <= 1'b0;
      end
      case (state_q)
        S_IDLE: begin
          // busy stays up after streaming until writeback reports done
          if (start_i && !busy_q) begin
            busy_q     <= 1'b1;
            num_rows_q <= num_rows_i;
            row_q      <= '0;
            ent_addr_q <= '0;
            state_q    <= S_FETCH;
          end
        end
        S_FETCH: begin
          first_q <= 1'b1;
          state_q <= S_STREAM;
        end
        S_STREAM: begin
          first_q    <= 1'b0;
          rem_q      <= len - 1'b1;
          ent_addr_q <= ent_addr_q + 1'b1;
          if (last_req) begin
            if (last_row) begin
              state_q <= S_IDLE;
            end else begin
              row_q   <= row_q + 1'b1;
              state_q <= S_FETCH;
            end
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_STREAM && first_q) begin
      meta_q <= '{row: row_q, src: node_i.src};
    end
  end

  assign busy_o      = busy_q;
  assign node_addr_o = row_q;
  assign ent_addr_o  = ent_addr_q;

  // entry data lags its address by one cycle
  assign ent_valid_o = req_q;
  assign ent_last_o  = req_last_q;
  assign ent_col_o   = ent_i.col;
  assign ent_val_o   = ent_i.val;
  assign meta_push_o = req_q && req_first_q;
  assign meta_o      = meta_q;

endmodule

`default_nettype wire

// ==== hdl/spmm_pkg.sv ====
`default_nettype none

package spmm_pkg;

  localparam int DATA_W       = 8;
  localparam int COL_IDX_W    = 4;
  localparam int ROW_LEN_W    = 4;
  localparam int ROW_W        = 4;
  localparam int ENTRY_ADDR_W = 6;
  localparam int ACC_W        = 20;

  // row counts run 1..MAX_ROWS, one bit wider than a row number
  localparam int MAX_ROWS   = 1 << ROW_W;
  localparam int NUM_ROWS_W = ROW_W + 1;

  typedef logic signed [DATA_W-1:0] data_t;

  typedef logic signed [ACC_W-1:0] acc_t;

  // one word per row of H
  typedef struct packed {
    logic [ROW_LEN_W-1:0] row_len;
    logic                 src;
  } node_info_t;

  // one nonzero of H
  typedef struct packed {
    logic [COL_IDX_W-1:0] col;
    data_t                val;
  } entry_t;

  // queued from controller to writeback
  typedef struct packed {
    logic [ROW_W-1:0] row;
    logic             src;
  } row_meta_t;

endpackage

`default_nettype wire

// ==== hdl/spmm_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module spmm_top import spmm_pkg::*; #(
  parameter int NUM_COLS = 4,
  parameter int WH_DEPTH = 12,
  parameter int META_DEPTH = 4,
  localparam int COL_SEL_W = $clog2(NUM_COLS),
  localparam int WH_AW = $clog2(WH_DEPTH)
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic [ENTRY_ADDR_W-1:0]   ld_addr_i,
  input  wire logic                      ld_node_we_i,
  input  wire node_info_t                ld_node_i,
  input  wire logic                      ld_entry_we_i,
  input  wire entry_t                    ld_entry_i,
  input  wire logic                      ld_weight_we_i,
  input  wire logic [COL_SEL_W-1:0]      ld_col_i,
  input  wire data_t                     ld_weight_i,
  input  wire logic                      start_i,
  input  wire logic [NUM_ROWS_W-1:0]     num_rows_i,
  output logic                           busy_o,
  output logic                           done_o,
  output logic                           wh_valid_o,
  output logic [WH_AW-1:0]               wh_addr_o,
  output logic                           wh_src_o,
  output logic [ROW_W-1:0]               wh_row_o,
  output logic [NUM_COLS*ACC_W-1:0]      wh_data_o
);

  logic [ROW_W-1:0]        node_addr;
  node_info_t              node_rd;
  logic [ENTRY_ADDR_W-1:0] ent_addr;
  entry_t                  ent_rd;
  logic                    ent_valid;
  logic [COL_IDX_W-1:0]    ent_col;
  data_t                   ent_val;
  logic                    ent_last;
  logic                    meta_push;
  logic                    meta_pop;
  row_meta_t               meta_in;
  row_meta_t               meta_out;
  logic [NUM_COLS-1:0]     pe_res_valid;
  logic [NUM_COLS*ACC_W-1:0] pe_res;
  logic                    run_start;

  // host writes only land while idle
  assign run_start = start_i && !busy_o;

  simple_dp_ram #(
    .T     (node_info_t),
    .DEPTH (MAX_ROWS)
  ) u_node_ram (
    .clk     (clk),
    .we_i    (ld_node_we_i && !busy_o),
    .waddr_i (ld_addr_i[ROW_W-1:0]),
    .wdata_i (ld_node_i),
    .raddr_i (node_addr),
    .rdata_o (node_rd)
  );

  simple_dp_ram #(
    .T     (entry_t),
    .DEPTH (2 ** ENTRY_ADDR_W)
  ) u_entry_ram (
    .clk     (clk),
    .we_i    (ld_entry_we_i && !busy_o),
    .waddr_i (ld_addr_i),
    .wdata_i (ld_entry_i),
    .raddr_i (ent_addr),
    .rdata_o (ent_rd)
  );

  spmm_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .num_rows_i  (num_rows_i),
    .done_i      (done_o),
    .busy_o      (busy_o),
    .node_addr_o (node_addr),
    .node_i      (node_rd),
    .ent_addr_o  (ent_addr),
    .ent_i       (ent_rd),
    .ent_valid_o (ent_valid),
    .ent_col_o   (ent_col),
    .ent_val_o   (ent_val),
    .ent_last_o  (ent_last),
    .meta_push_o (meta_push),
    .meta_o      (meta_in)
  );

  for (genvar i = 0; i < NUM_COLS; i++) begin : g_pe
    sp_pe u_pe (
      .clk         (clk),
      .rst_n       (rst_n),
      .ld_we_i     (ld_weight_we_i && !busy_o && (ld_col_i == COL_SEL_W'(i))),
      .ld_addr_i   (ld_addr_i[COL_IDX_W-1:0]),
      .ld_data_i   (ld_weight_i),
      .ent_valid_i (ent_valid),
      .ent_col_i   (ent_col),
      .ent_val_i   (ent_val),
      .ent_last_i  (ent_last),
      .res_valid_o (pe_res_valid[i]),
      .res_o       (pe_res[i*ACC_W +: ACC_W])
    );
  end

  sync_fifo #(
    .T     (row_meta_t),
    .DEPTH (META_DEPTH)
  ) u_meta_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (meta_push),
    .pop_i   (meta_pop),
    .data_i  (meta_in),
    .data_o  (meta_out),
    .empty_o (),
    .full_o  ()
  );

  // all PEs run in lockstep
  wh_writeback #(
    .NUM_COLS (NUM_COLS),
    .WH_DEPTH (WH_DEPTH)
  ) u_writeback (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (run_start),
    .num_rows_i  (num_rows_i),
    .res_valid_i (pe_res_valid[0]),
    .res_i       (pe_res),
    .meta_i      (meta_out),
    .meta_pop_o  (meta_pop),
    .wh_valid_o  (wh_valid_o),
    .wh_addr_o   (wh_addr_o),
    .wh_src_o    (wh_src_o),
    .wh_row_o    (wh_row_o),
    .wh_data_o   (wh_data_o),
    .done_o      (done_o)
  );

endmodule

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
  parameter type T = logic [7:0],
  parameter int DEPTH = 4,
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic push_i,
  input  wire logic pop_i,
  input  wire T     data_i,
  output T          data_o,
  output logic      empty_o,
  output logic      full_o
);

  T mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_push;
  logic          do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head of queue is visible without a pop
  assign data_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign full_o  = (count == (AW + 1)'(DEPTH));

endmodule

`default_nettype wire

// ==== hdl/wh_writeback.sv ====
`timescale 1ns/1ns
`default_nettype none

module wh_writeback import spmm_pkg::*; #(
  parameter int NUM_COLS = 4,
  parameter int WH_DEPTH = 12,
  localparam int AW = $clog2(WH_DEPTH)
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      start_i,
  input  wire logic [NUM_ROWS_W-1:0]     num_rows_i,
  input  wire logic                      res_valid_i,
  input  wire logic [NUM_COLS*ACC_W-1:0] res_i,
  input  wire row_meta_t                 meta_i,
  output logic                           meta_pop_o,
  output logic                           wh_valid_o,
  output logic [AW-1:0]                  wh_addr_o,
  output logic                           wh_src_o,
  output logic [ROW_W-1:0]               wh_row_o,
  output logic [NUM_COLS*ACC_W-1:0]      wh_data_o,
  output logic                           done_o
);

  logic [AW-1:0]         addr_q;
  logic [NUM_ROWS_W-1:0] target_q;
  logic [NUM_ROWS_W-1:0] cnt_q;
  logic [NUM_ROWS_W-1:0] cnt_nxt;

  assign meta_pop_o = res_valid_i;
  assign cnt_nxt    = cnt_q + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wh_valid_o <= 1'b0;
      done_o     <= 1'b0;
      addr_q     <= '0;
      cnt_q      <= '0;
      target_q   <= '0;
    end else begin
      wh_valid_o <= res_valid_i;
      done_o     <= 1'b0;
      if (start_i) begin
        target_q <= num_rows_i;
        cnt_q    <= '0;
      end else if (wh_valid_o) begin
        cnt_q  <= cnt_nxt;
        done_o <= (cnt_nxt == target_q);
      end
      // address keeps running across runs
      if (wh_valid_o) begin
        addr_q <= (addr_q == AW'(WH_DEPTH - 1)) ? '0 : addr_q + 1'b1;
      end
    end
  end

  // PE i sits at bits [i*ACC_W +: ACC_W]
  always_ff @(posedge clk) begin
    if (res_valid_i) begin
      wh_data_o <= res_i;
      wh_src_o  <= meta_i.src;
      wh_row_o  <= meta_i.row;
    end
  end

  assign wh_addr_o = addr_q;

endmodule

`default_nettype wire

// ==== verification/clk_rst_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clk_rst_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release just after an edge, like the rest of the stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/spmm_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module spmm_sva (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic busy_i,
  input wire logic ent_valid_i,
  input wire logic ent_last_i,
  input wire logic meta_push_i,
  input wire logic meta_pop_i,
  input wire logic res_valid_i,
  input wire logic done_i
);

  logic [3:0] meta_occ;
  logic [3:0] rows_open;
  int         fail_count = 0;

  // shadow counts of queued metadata and rows still in the PEs
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      meta_occ  <= '0;
      rows_open <= '0;
    end else begin
      meta_occ  <= meta_occ + 4'(meta_push_i) - 4'(meta_pop_i);
      rows_open <= rows_open + 4'(ent_valid_i && ent_last_i) - 4'(res_valid_i);
    end
  end

  ap_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    meta_pop_i |-> meta_occ != 4'd0)
    else begin
      fail_count++;
      $error("metadata FIFO popped while empty");
    end

  ap_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |=> !done_i)
    else begin
      fail_count++;
      $error("done held longer than one cycle");
    end

  ap_valid_busy: assert property (@(posedge clk) disable iff (!rst_n)
    ent_valid_i |-> busy_i)
    else begin
      fail_count++;
      $error("entry issued while not busy");
    end

  ap_res_after_last: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid_i |-> rows_open != 4'd0)
    else begin
      fail_count++;
      $error("result without a preceding last entry");
    end

endmodule

// top level sees both controller and writeback sides of the FIFO
bind spmm_top spmm_sva u_sva (
  .clk         (clk),
  .rst_n       (rst_n),
  .busy_i      (busy_o),
  .ent_valid_i (ent_valid),
  .ent_last_i  (ent_last),
  .meta_push_i (meta_push),
  .meta_pop_i  (meta_pop),
  .res_valid_i (pe_res_valid[0]),
  .done_i      (done_o)
);

`default_nettype wire

// ==== verification/spmm_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module spmm_tb import spmm_pkg::*; ();

  localparam int NUM_COLS  = 4;
  localparam int WH_DEPTH  = 12;
  localparam int WH_AW     = $clog2(WH_DEPTH);
  localparam int COL_SEL_W = $clog2(NUM_COLS);
  localparam int ENT_DEPTH = 1 << ENTRY_ADDR_W;
  localparam int W_DEPTH   = 1 << COL_IDX_W;
  localparam data_t MIN_VAL = data_t'(8'h80);
  localparam data_t MAX_VAL = data_t'(8'h7f);

  logic                      clk;
  logic                      rst_n;
  logic [ENTRY_ADDR_W-1:0]   ld_addr;
  logic                      ld_node_we;
  node_info_t                ld_node;
  logic                      ld_entry_we;
  entry_t                    ld_entry;
  logic                      ld_weight_we;
  logic [COL_SEL_W-1:0]      ld_col;
  data_t                     ld_weight;
  logic                      start;
  logic [NUM_ROWS_W-1:0]     num_rows;
  logic                      busy;
  logic                      done;
  logic                      wh_valid;
  logic [WH_AW-1:0]          wh_addr;
  logic                      wh_src;
  logic [ROW_W-1:0]          wh_row;
  logic [NUM_COLS*ACC_W-1:0] wh_data;

  // model memories
  node_info_t node_mem [MAX_ROWS];
  entry_t     ent_mem [ENT_DEPTH];
  data_t      w_mem [NUM_COLS][W_DEPTH];

  row_meta_t        exp_meta_q [$];
  logic [WH_AW-1:0] exp_addr_q [$];
  acc_t             exp_acc_q [$];

  int wr_total = 0;
  int err_value = 0;
  int err_other = 0;
  int rec_count = 0;
  int done_count = 0;
  int cycles = 0;
  int limit_cycles = 20;

  clk_rst_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  spmm_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ld_addr_i      (ld_addr),
    .ld_node_we_i   (ld_node_we),
    .ld_node_i      (ld_node),
    .ld_entry_we_i  (ld_entry_we),
    .ld_entry_i     (ld_entry),
    .ld_weight_we_i (ld_weight_we),
    .ld_col_i       (ld_col),
    .ld_weight_i    (ld_weight),
    .start_i        (start),
    .num_rows_i     (num_rows),
    .busy_o         (busy),
    .done_o         (done),
    .wh_valid_o     (wh_valid),
    .wh_addr_o      (wh_addr),
    .wh_src_o       (wh_src),
    .wh_row_o       (wh_row),
    .wh_data_o      (wh_data)
  );

  task automatic note_failure(string msg);
    $display("error at %0t: %s", $time, msg);
    err_other++;
  endtask

  task automatic check_acc(string name, acc_t got, acc_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
      err_value++;
    end
  endtask

  task automatic check_record(row_meta_t got_meta, logic [WH_AW-1:0] got_addr,
                              row_meta_t exp_meta, logic [WH_AW-1:0] exp_addr);
    if (got_meta.row !== exp_meta.row) begin
      $display("** Error: wh_row_o got 0x%h expected 0x%h", got_meta.row, exp_meta.row);
      err_value++;
    end
    if (got_meta.src !== exp_meta.src) begin
      $display("** Error: wh_src_o got 0x%h expected 0x%h", got_meta.src, exp_meta.src);
      err_value++;
    end
    if (got_addr !== exp_addr) begin
      $display("** Error: wh_addr_o got 0x%h expected 0x%h", got_addr, exp_addr);
      err_value++;
    end
  endtask

  task automatic check_output();
    row_meta_t        got_meta;
    row_meta_t        exp_meta;
    logic [WH_AW-1:0] exp_addr;
    acc_t             exp_acc;
    got_meta.row = wh_row;
    got_meta.src = wh_src;
    exp_meta = exp_meta_q.pop_front();
    exp_addr = exp_addr_q.pop_front();
    check_record(got_meta, wh_addr, exp_meta, exp_addr);
    for (int c = 0; c < NUM_COLS; c++) begin
      exp_acc = exp_acc_q.pop_front();
      check_acc($sformatf("wh_data_o[%0d]", c), wh_data[c*ACC_W +: ACC_W], exp_acc);
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (rst_n && wh_valid) begin
      rec_count++;
      if (exp_meta_q.size() == 0) begin
        note_failure("record written when none was expected");
      end else begin
        check_output();
      end
    end
    if (rst_n && done) begin
      done_count++;
    end
  end

  initial begin
    while (cycles <= limit_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", limit_cycles);
    $display("Something failed");
    $finish;
  end

  task automatic write_node(int a, node_info_t v);
    ld_addr = ENTRY_ADDR_W'(a);
    ld_node = v;
    ld_node_we = 1'b1;
    @(posedge clk);
    #2;
    ld_node_we = 1'b0;
    node_mem[a] = v;
    limit_cycles += 1;
  endtask

  task automatic write_entry(int a, entry_t v);
    ld_addr = ENTRY_ADDR_W'(a);
    ld_entry = v;
    ld_entry_we = 1'b1;
    @(posedge clk);
    #2;
    ld_entry_we = 1'b0;
    ent_mem[a] = v;
    limit_cycles += 1;
  endtask

  task automatic write_weight(int col, int a, data_t v);
    ld_addr = ENTRY_ADDR_W'(a);
    ld_col = COL_SEL_W'(col);
    ld_weight = v;
    ld_weight_we = 1'b1;
    @(posedge clk);
    #2;
    ld_weight_we = 1'b0;
    w_mem[col][a] = v;
    limit_cycles += 1;
  endtask

  task automatic fill_weights();
    for (int c = 0; c < NUM_COLS; c++) begin
      for (int a = 0; a < W_DEPTH; a++) begin
        write_weight(c, a, data_t'($urandom));
      end
    end
  endtask

  task automatic fill_matrix();
    node_info_t n;
    entry_t     e;
    for (int r = 0; r < MAX_ROWS; r++) begin
      n.row_len = ROW_LEN_W'(1 + $urandom % 15);
      n.src = 1'($urandom);
      write_node(r, n);
    end
    for (int a = 0; a < ENT_DEPTH; a++) begin
      e.col = COL_IDX_W'($urandom);
      e.val = data_t'($urandom);
      write_entry(a, e);
    end
  endtask

  // two full rows at the signed corners
  task automatic load_extremes();
    write_node(0, node_info_t'{row_len: 4'd15, src: 1'b0});
    write_node(1, node_info_t'{row_len: 4'd15, src: 1'b1});
    for (int k = 0; k < 15; k++) begin
      write_entry(k, entry_t'{col: COL_IDX_W'(k), val: MIN_VAL});
      write_entry(15 + k, entry_t'{col: COL_IDX_W'(k), val: MAX_VAL});
    end
    for (int c = 0; c < NUM_COLS; c++) begin
      for (int a = 0; a < W_DEPTH; a++) begin
        write_weight(c, a, MIN_VAL);
      end
    end
  endtask

  // entry address restarts at 0 each run and wraps with the entry memory
  task automatic predict(int rows);
    int        sum [NUM_COLS];
    int        addr;
    entry_t    e;
    row_meta_t m;
    addr = 0;
    for (int r = 0; r < rows; r++) begin
      foreach (sum[c]) sum[c] = 0;
      for (int k = 0; k < int'(node_mem[r].row_len); k++) begin
        e = ent_mem[addr % ENT_DEPTH];
        for (int c = 0; c < NUM_COLS; c++) begin
          sum[c] += int'(e.val) * int'(w_mem[c][e.col]);
        end
        addr++;
      end
      m.row = ROW_W'(r);
      m.src = node_mem[r].src;
      exp_meta_q.push_back(m);
      exp_addr_q.push_back(WH_AW'(wr_total % WH_DEPTH));
      wr_total++;
      for (int c = 0; c < NUM_COLS; c++) begin
        exp_acc_q.push_back(acc_t'(sum[c]));
      end
      limit_cycles += int'(node_mem[r].row_len) + 3;
    end
    limit_cycles += 50;
  endtask

  task automatic run_matrix(int rows, bit poke);
    int rec_before;
    int done_before;
    predict(rows);
    rec_before = rec_count;
    done_before = done_count;
    start = 1'b1;
    num_rows = NUM_ROWS_W'(rows);
    @(posedge clk);
    #2;
    start = 1'b0;
    if (poke) begin
      // second start and a weight write, both while busy
      repeat (2) @(posedge clk);
      #2;
      start = 1'b1;
      num_rows = NUM_ROWS_W'(MAX_ROWS);
      ld_col = '0;
      ld_addr = '0;
      ld_weight = data_t'(8'h55);
      ld_weight_we = 1'b1;
      @(posedge clk);
      #2;
      start = 1'b0;
      ld_weight_we = 1'b0;
      // again in the done cycle, controller idle but busy still up
      while (rec_count - rec_before < rows) @(posedge clk);
      #2;
      start = 1'b1;
      @(posedge clk);
      #2;
      start = 1'b0;
    end
    while (done_count == done_before) @(posedge clk);
    #2;
    if (busy !== 1'b0) begin
      note_failure("busy still high after done");
    end
    repeat (3) @(posedge clk);
    #2;
    if (rec_count - rec_before != rows) begin
      note_failure($sformatf("run of %0d rows wrote %0d records", rows,
                             rec_count - rec_before));
    end
    if (done_count - done_before != 1) begin
      note_failure("done pulsed more than once in one run");
    end
    if (exp_meta_q.size() != 0) begin
      note_failure("expected records still queued after done");
      exp_meta_q.delete();
      exp_addr_q.delete();
      exp_acc_q.delete();
    end
  endtask

  initial begin
    void'($urandom(32'h316f_ca38));
    ld_addr = '0;
    ld_node_we = 1'b0;
    ld_node = '0;
    ld_entry_we = 1'b0;
    ld_entry = '0;
    ld_weight_we = 1'b0;
    ld_col = '0;
    ld_weight = '0;
    start = 1'b0;
    num_rows = '0;
    @(posedge rst_n);
    @(posedge clk);
    #2;
    fill_weights();
    fill_matrix();

    // one row, one nonzero
    write_node(0, node_info_t'{row_len: 4'd1, src: 1'b1});
    write_entry(0, entry_t'{col: 4'd9, val: data_t'(8'hf9)});
    run_matrix(1, 1'b0);

    repeat (2) begin
      fill_matrix();
      run_matrix(MAX_ROWS, 1'b0);
    end

    load_extremes();
    run_matrix(2, 1'b0);

    // short runs back to back, address wraps several times
    fill_weights();
    fill_matrix();
    repeat (4) run_matrix(1 + int'($urandom % 6), 1'b0);

    run_matrix(6, 1'b1);
    write_node(0, node_info_t'{row_len: 4'd2, src: 1'b0});
    write_entry(0, entry_t'{col: 4'd2, val: MAX_VAL});
    write_weight(2, 2, data_t'(8'hff));
    write_weight(0, 0, data_t'(8'h03));
    run_matrix(3, 1'b0);

    $display("summary: %0d value errors, %0d other errors, %0d assertion failures",
             err_value, err_other, dut_i.u_sva.fail_count);
    if (err_value + err_other + dut_i.u_sva.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
